//--- verilog/npu_pkg.sv
package npu_pkg;

    // one matrix element
    typedef logic [7:0] operand_t;

    // accumulator and result value, wraps modulo 2^32
    typedef logic [31:0] acc_t;

    // row-major element index inside one matrix
    typedef logic [3:0] addr_t;

    typedef enum logic {
        mat_a,
        mat_b
    } mat_sel_t;

    typedef enum logic [1:0] {
        st_idle,
        st_feed,
        st_drain,
        st_result
    } ctrl_state_t;

endpackage

//--- verilog/operand_if.sv
`timescale 1ns/1ps

interface operand_if import npu_pkg::*; #(
    parameter int dim = 3
) ();

    // left edge, one per row
    operand_t a_edge [dim];
    // top edge, one per column
    operand_t b_edge [dim];
    logic     feed;
    logic     clear;
    // row-major accumulators
    acc_t     acc [dim*dim];

    modport controller (
        output a_edge, b_edge, feed, clear,
        input  acc
    );

    modport array (
        input  a_edge, b_edge, feed, clear,
        output acc
    );

endinterface

//--- verilog/processing_element.sv
`timescale 1ns/1ps

module processing_element import npu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  operand_t a_in,
    input  operand_t b_in,
    input  logic     step,
    input  logic     clear,
    output operand_t a_out,
    output operand_t b_out,
    output acc_t     acc
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else if (clear) begin
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else if (step) begin
            // widen before multiplying so the product is not cut to 8 bits
            acc   <= acc + acc_t'(a_in) * acc_t'(b_in);
            a_out <= a_in;
            b_out <= b_in;
        end
    end

    // controller never clears during a feed window
    assert property (@(posedge clk) disable iff (rst) !(clear && step))
        else $error("pe: clear and step high together");

endmodule

//--- verilog/systolic_array.sv
`timescale 1ns/1ps

module systolic_array import npu_pkg::*; #(
    parameter int dim = 3
) (
    input logic     clk,
    input logic     rst,
    operand_if.array ops
);

    // registered operands leaving each cell
    operand_t a_grid [dim][dim];
    operand_t b_grid [dim][dim];

    for (genvar r = 0; r < dim; r++) begin : g_row
        for (genvar c = 0; c < dim; c++) begin : g_col
            operand_t a_src;
            operand_t b_src;
            acc_t     acc_cell;

            // a flows right, b flows down
            if (c == 0) begin : g_a_edge
                assign a_src = ops.a_edge[r];
            end else begin : g_a_chain
                assign a_src = a_grid[r][c-1];
            end

            if (r == 0) begin : g_b_edge
                assign b_src = ops.b_edge[c];
            end else begin : g_b_chain
                assign b_src = b_grid[r-1][c];
            end

            processing_element u_pe (
                .clk   (clk),
                .rst   (rst),
                .a_in  (a_src),
                .b_in  (b_src),
                .step  (ops.feed),
                .clear (ops.clear),
                .a_out (a_grid[r][c]),
                .b_out (b_grid[r][c]),
                .acc   (acc_cell)
            );

            assign ops.acc[r*dim + c] = acc_cell;
        end
    end

endmodule

//--- verilog/npu_controller.sv
`timescale 1ns/1ps

module npu_controller import npu_pkg::*; #(
    parameter int dim = 3
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     load_valid,
    output logic     load_ready,
    input  mat_sel_t load_sel,
    input  addr_t    load_addr,
    input  operand_t load_data,

    input  logic     start_valid,
    output logic     start_ready,

    output logic     res_valid,
    input  logic     res_ready,
    output addr_t    res_addr,
    output acc_t     res_data,

    operand_if.controller ops
);

    // number of skewed diagonals fed into the array
    localparam int feed_len = 3*dim - 2;
    localparam int cnt_w    = $clog2(feed_len + 1);
    localparam int n_elem   = dim*dim;

    ctrl_state_t state;
    logic [cnt_w-1:0] cnt;

    operand_t mem_a [n_elem];
    operand_t mem_b [n_elem];

    operand_t a_next [dim];
    operand_t b_next [dim];

    logic  load_fire;
    logic  start_fire;
    logic  res_fire;
    logic  res_last;
    addr_t res_next;

    assign load_ready  = (state == st_idle);
    assign start_ready = (state == st_idle);
    assign load_fire   = load_valid && load_ready;
    assign start_fire  = start_valid && start_ready;
    assign res_fire    = res_valid && res_ready;
    assign res_last    = (res_addr == addr_t'(n_elem - 1));
    assign res_next    = res_addr + 1'b1;

    // operand memories, written only while idle
    always_ff @(posedge clk) begin
        if (load_fire) begin
            if (load_sel == mat_a) begin
                mem_a[load_addr] <= load_data;
            end else begin
                mem_b[load_addr] <= load_data;
            end
        end
    end

    // diagonal t: row r gets A[r][t-r], column c gets B[t-c][c]
    always_comb begin
        for (int r = 0; r < dim; r++) begin
            a_next[r] = '0;
            b_next[r] = '0;
            if (state == st_feed && int'(cnt) >= r && int'(cnt) - r < dim) begin
                a_next[r] = mem_a[r*dim + int'(cnt) - r];
                b_next[r] = mem_b[(int'(cnt) - r)*dim + r];
            end
        end
    end

    // edge operands are registered, so they line up with the registered feed
    always_ff @(posedge clk) begin
        for (int r = 0; r < dim; r++) begin
            ops.a_edge[r] <= a_next[r];
            ops.b_edge[r] <= b_next[r];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            cnt       <= '0;
            ops.clear <= 1'b0;
            ops.feed  <= 1'b0;
            res_valid <= 1'b0;
            res_addr  <= '0;
        end else begin
            // one-cycle clear right after the start edge
            ops.clear <= start_fire;
            ops.feed  <= (state == st_feed);

            case (state)
                st_idle: begin
                    if (start_fire) begin
                        state <= st_feed;
                        cnt   <= '0;
                    end
                end
                st_feed: begin
                    if (int'(cnt) == feed_len - 1) begin
                        state <= st_drain;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_drain: begin
                    // last diagonal is still on the bus this cycle
                    state    <= st_result;
                    res_addr <= '0;
                end
                st_result: begin
                    if (!res_valid) begin
                        res_valid <= 1'b1;
                    end else if (res_ready) begin
                        if (res_last) begin
                            res_valid <= 1'b0;
                            state     <= st_idle;
                        end else begin
                            res_addr <= res_next;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // result register, array is frozen so the next value can be fetched ahead
    always_ff @(posedge clk) begin
        if (state == st_result) begin
            if (!res_valid) begin
                res_data <= ops.acc[res_addr];
            end else if (res_fire && !res_last) begin
                res_data <= ops.acc[res_next];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(load_ready && res_valid))
        else $error("ctrl: load accepted while a result is pending");

    assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_addr) && $stable(res_data))
        else $error("ctrl: stalled result changed");

    assert property (@(posedge clk) disable iff (rst) int'(cnt) <= feed_len - 1)
        else $error("ctrl: feed counter out of range");

endmodule

//--- verilog/npu_top.sv
`timescale 1ns/1ps

module npu_top import npu_pkg::*; #(
    parameter int dim = 3
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     load_valid,
    output logic     load_ready,
    input  mat_sel_t load_sel,
    input  addr_t    load_addr,
    input  operand_t load_data,

    input  logic     start_valid,
    output logic     start_ready,

    output logic     res_valid,
    input  logic     res_ready,
    output addr_t    res_addr,
    output acc_t     res_data
);

    operand_if #(.dim(dim)) ops_bus ();

    npu_controller #(.dim(dim)) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_sel    (load_sel),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res_addr    (res_addr),
        .res_data    (res_data),
        .ops         (ops_bus.controller)
    );

    systolic_array #(.dim(dim)) u_array (
        .clk (clk),
        .rst (rst),
        .ops (ops_bus.array)
    );

endmodule

//--- test/tb_npu_top.sv
`timescale 1ns/1ps

module tb_npu_top import npu_pkg::*; ();

    localparam int dim      = 3;
    localparam int n_elem   = dim*dim;
    localparam int n_rows   = 7;
    localparam int wait_max = 100;

    logic     clk;
    logic     rst;
    logic     load_valid;
    logic     load_ready;
    mat_sel_t load_sel;
    addr_t    load_addr;
    operand_t load_data;
    logic     start_valid;
    logic     start_ready;
    logic     res_valid;
    logic     res_ready;
    addr_t    res_addr;
    acc_t     res_data;

    // one matrix pair per row, plus max stall per result and reload flag
    operand_t tbl_a [n_rows][n_elem];
    operand_t tbl_b [n_rows][n_elem];
    int       tbl_stall [n_rows];
    bit       tbl_reload [n_rows];

    int mismatches;
    int failures;
    bit timed_out;

    npu_top #(.dim(dim)) i_dut (.*);

    always #4 clk = ~clk;

    task automatic check_acc(string name, acc_t got, acc_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_timeout(string what);
        $display("timeout at %0t: no %s within %0d cycles", $time, what, wait_max);
        failures++;
        timed_out = 1'b1;
    endtask

    // plain matrix product, element r,c of A times B
    function automatic acc_t ref_product(int row, int idx);
        acc_t sum;
        int   r;
        int   c;
        sum = '0;
        r = idx / dim;
        c = idx % dim;
        for (int k = 0; k < dim; k++) begin
            sum += acc_t'(tbl_a[row][r*dim + k]) * acc_t'(tbl_b[row][k*dim + c]);
        end
        return sum;
    endfunction

    task automatic build_table();
        for (int i = 0; i < n_elem; i++) begin
            tbl_a[0][i] = (i % (dim + 1) == 0) ? 8'd1 : 8'd0;
            tbl_b[0][i] = operand_t'($urandom);
            tbl_a[1][i] = '0;
            tbl_b[1][i] = '0;
            tbl_a[2][i] = 8'hff;
            tbl_b[2][i] = 8'hff;
            tbl_a[3][i] = operand_t'(i + 1);
            tbl_b[3][i] = operand_t'(i + 1);
            tbl_a[4][i] = operand_t'($urandom);
            tbl_b[4][i] = operand_t'($urandom);
            tbl_a[5][i] = operand_t'($urandom);
            tbl_b[5][i] = operand_t'($urandom);
            // rerun of row 5 from the memories as they stand
            tbl_a[6][i] = tbl_a[5][i];
            tbl_b[6][i] = tbl_b[5][i];
        end
        tbl_stall  = '{0, 3, 0, 4, 2, 0, 5};
        tbl_reload = '{1, 1, 1, 1, 1, 1, 0};
    endtask

    task automatic load_word(mat_sel_t sel, addr_t addr, operand_t data);
        int waited;
        waited     = 0;
        load_valid = 1'b1;
        load_sel   = sel;
        load_addr  = addr;
        load_data  = data;
        while (!load_ready && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited >= wait_max) begin
                report_timeout("load_ready");
            end
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic start_run();
        int waited;
        waited      = 0;
        start_valid = 1'b1;
        while (!start_ready && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited >= wait_max) begin
                report_timeout("start_ready");
            end
        end
        @(negedge clk);
        start_valid = 1'b0;
        // stray loads are offered for the whole run
        load_valid  = 1'b1;
    endtask

    // a cycle while busy, loads and starts must be refused
    task automatic busy_cycle();
        check_flag("load_ready", load_ready, 1'b0);
        check_flag("start_ready", start_ready, 1'b0);
        @(negedge clk);
        load_sel  = ($urandom % 2 == 0) ? mat_a : mat_b;
        load_addr = addr_t'($urandom % n_elem);
        load_data = operand_t'($urandom);
    endtask

    task automatic collect_results(int row);
        int    waited;
        int    stall;
        addr_t held_addr;
        acc_t  held_data;
        for (int i = 0; i < n_elem && !timed_out; i++) begin
            waited    = 0;
            res_ready = 1'b0;
            while (!res_valid && !timed_out) begin
                busy_cycle();
                waited++;
                if (waited >= wait_max) begin
                    report_timeout("res_valid");
                end
            end
            if (!timed_out) begin
                stall     = int'($urandom % (tbl_stall[row] + 1));
                held_addr = res_addr;
                held_data = res_data;
                repeat (stall) begin
                    busy_cycle();
                    check_flag("res_valid", res_valid, 1'b1);
                    check_addr("res_addr", res_addr, held_addr);
                    check_acc("res_data", res_data, held_data);
                end
                check_addr("res_addr", res_addr, addr_t'(i));
                check_acc("res_data", res_data, ref_product(row, i));
                res_ready = 1'b1;
                busy_cycle();
                res_ready = 1'b0;
            end
        end
        load_valid = 1'b0;
    endtask

    task automatic run_row(int row);
        if (tbl_reload[row]) begin
            for (int i = 0; i < n_elem && !timed_out; i++) begin
                load_word(mat_a, addr_t'(i), tbl_a[row][i]);
                load_word(mat_b, addr_t'(i), tbl_b[row][i]);
            end
        end
        if (!timed_out) begin
            start_run();
        end
        if (!timed_out) begin
            collect_results(row);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        load_valid  = 1'b0;
        load_sel    = mat_a;
        load_addr   = '0;
        load_data   = '0;
        start_valid = 1'b0;
        res_ready   = 1'b0;
        mismatches  = 0;
        failures    = 0;
        timed_out   = 1'b0;
        void'($urandom(32'h3b42));
        build_table();

        repeat (3) @(negedge clk);
        check_flag("res_valid", res_valid, 1'b0);
        check_flag("load_ready", load_ready, 1'b1);
        check_flag("start_ready", start_ready, 1'b1);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("res_valid", res_valid, 1'b0);
        check_flag("load_ready", load_ready, 1'b1);
        check_flag("start_ready", start_ready, 1'b1);

        for (int row = 0; row < n_rows && !timed_out; row++) begin
            run_row(row);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (timed_out || mismatches != 0 || failures != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

//--- npu_mm.f
verilog/npu_pkg.sv
verilog/operand_if.sv
verilog/processing_element.sv
verilog/systolic_array.sv
verilog/npu_controller.sv
verilog/npu_top.sv
test/tb_npu_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the npu testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_npu_top \
    -f npu_mm.f -Mdir obj_dir -o sim_npu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_npu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$log"; then
    exit 1
fi
exit 0
